// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "test   build and run the testbench with Verilator"
	@echo "clean  remove build output"

test:
	verilator --binary --timing -f id_stage.f --top-module tb_id_stage -Mdir obj_dir -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage import id_pkg::*; ();

	// expected combinational and registered results of one decode cycle
	typedef struct packed {
		logic        r1en;
		logic        r2en;
		logic [4:0]  a1;
		logic [4:0]  a2;
		logic        stall;
		logic        bflag;
		logic [31:0] btarget;
		id_ex_t      ex;
	} exp_t;

	localparam int K_NONE = 0;
	localparam int K_ALW  = 1;
	localparam int K_EQ   = 2;
	localparam int K_NE   = 3;
	localparam int K_GTZ  = 4;
	localparam int K_LEZ  = 5;
	localparam int K_GEZ  = 6;
	localparam int K_LTZ  = 7;

	logic clk = 1'b0;
	logic arst_n;
	logic id_valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic [31:0] rf1;
	logic [31:0] rf2;
	alu_op_e     ex_aluop;
	logic        ex_wreg;
	logic [4:0]  ex_wd;
	logic [31:0] ex_wdata;
	logic        mem_wreg;
	logic [4:0]  mem_wd;
	logic [31:0] mem_wdata;
	logic        reg1_read;
	logic        reg2_read;
	logic [4:0]  reg1_addr;
	logic [4:0]  reg2_addr;
	logic        stall;
	logic        branch_flag;
	logic [31:0] branch_target;
	logic        ex_valid;
	alu_op_e     ex_aluop_q;
	alu_sel_e    ex_alusel_q;
	logic [31:0] ex_reg1;
	logic [31:0] ex_reg2;
	logic [4:0]  ex_wd_q;
	logic        ex_wreg_q;
	logic [31:0] ex_link;
	logic        ex_in_ds;
	logic        ex_illegal;

	// forwarding values applied at the next falling edge
	alu_op_e     s_ex_aluop;
	logic        s_ex_wreg;
	logic [4:0]  s_ex_wd;
	logic [31:0] s_ex_wdata;
	logic        s_mem_wreg;
	logic [4:0]  s_mem_wd;
	logic [31:0] s_mem_wdata;

	integer seed = 32'h6846_633d;
	logic   ds_pending;
	string  test_name;
	id_ex_t exp_q[$];

	id_stage u_dut (
		.clk(clk), .arst_n_i(arst_n), .id_valid_i(id_valid), .pc_i(pc), .inst_i(inst),
		.reg1_data_i(rf1), .reg2_data_i(rf2), .ex_aluop_i(ex_aluop), .ex_wreg_i(ex_wreg),
		.ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata), .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd),
		.mem_wdata_i(mem_wdata), .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
		.reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr), .stall_o(stall),
		.branch_flag_o(branch_flag), .branch_target_o(branch_target),
		.ex_valid_o(ex_valid), .ex_aluop_o(ex_aluop_q), .ex_alusel_o(ex_alusel_q),
		.ex_reg1_o(ex_reg1), .ex_reg2_o(ex_reg2), .ex_wd_o(ex_wd_q), .ex_wreg_o(ex_wreg_q),
		.ex_link_addr_o(ex_link), .ex_in_delayslot_o(ex_in_ds), .ex_illegal_o(ex_illegal)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	initial begin
		#500000;
		$display("simulation did not finish in time");
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error %s %s: expected %h, actual %h", test_name, name, exp, act);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	function automatic logic [31:0] pick_operand(input logic en, input logic [4:0] addr,
		input logic [31:0] rf, input logic [31:0] imm);
		if (!en)
			return imm;
		if (ex_wreg && ex_wd == addr)
			return ex_wdata;	// youngest writer first
		if (mem_wreg && mem_wd == addr)
			return mem_wdata;
		return rf;
	endfunction

	//////////////////////////////
	// reference decoder
	//////////////////////////////
	function automatic exp_t ref_decode(input logic [31:0] ins, input logic [31:0] pcv,
		input logic [31:0] d1, input logic [31:0] d2, input logic valid);
		exp_t        e;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  sh;
		logic [31:0] imm;
		logic [31:0] pc4;
		logic        lnk;
		logic        ill;
		int          kind;
		op = ins[31:26];
		fn = ins[5:0];
		rs = ins[25:21];
		rt = ins[20:16];
		sh = ins[10:6];
		e = '0;
		imm = '0;
		lnk = 1'b0;
		ill = 1'b0;
		kind = K_NONE;
		e.a1 = rs;
		e.a2 = rt;
		e.ex.valid = 1'b1;
		e.ex.wd = ins[15:11];
		case (op)
			OP_SPECIAL: begin
				e.r1en = 1'b1;
				e.r2en = 1'b1;
				e.ex.wreg = 1'b1;
				ill = (sh != 5'd0);
				case (fn)
					FN_OR:   e.ex.aluop = ALU_OR;
					FN_AND:  e.ex.aluop = ALU_AND;
					FN_XOR:  e.ex.aluop = ALU_XOR;
					FN_NOR:  e.ex.aluop = ALU_NOR;
					FN_ADDU: e.ex.aluop = ALU_ADDU;
					FN_SUBU: e.ex.aluop = ALU_SUBU;
					FN_SLT:  e.ex.aluop = ALU_SLT;
					FN_SLTU: e.ex.aluop = ALU_SLTU;
					FN_SLL, FN_SLLV: e.ex.aluop = ALU_SLL;
					FN_SRL, FN_SRLV: e.ex.aluop = ALU_SRL;
					FN_SRA, FN_SRAV: e.ex.aluop = ALU_SRA;
					FN_JR:   e.ex.aluop = ALU_JR;
					FN_JALR: e.ex.aluop = ALU_JALR;
					default: ill = 1'b1;
				endcase
				e.ex.alusel = SEL_ARITH;
				if (e.ex.aluop inside {ALU_OR, ALU_AND, ALU_XOR, ALU_NOR})
					e.ex.alusel = SEL_LOGIC;
				if (e.ex.aluop inside {ALU_SLL, ALU_SRL, ALU_SRA})
					e.ex.alusel = SEL_SHIFT;
				if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
					e.r1en = 1'b0;	// shamt as operand 1
					imm = {27'd0, sh};
					ill = (rs != 5'd0);
				end
				if (fn == FN_JR || fn == FN_JALR) begin
					e.r2en = 1'b0;
					e.ex.alusel = SEL_JB;
					kind = K_ALW;
					e.ex.wreg = (fn == FN_JALR);
					lnk = (fn == FN_JALR);
				end
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				e.r1en = 1'b1;
				e.ex.wreg = 1'b1;
				e.ex.wd = rt;
				case (op)
					OP_ORI:   e.ex.aluop = ALU_OR;
					OP_ANDI:  e.ex.aluop = ALU_AND;
					OP_XORI:  e.ex.aluop = ALU_XOR;
					OP_LUI:   e.ex.aluop = ALU_LUI;
					OP_ADDIU: e.ex.aluop = ALU_ADDU;
					OP_SLTI:  e.ex.aluop = ALU_SLT;
					default:  e.ex.aluop = ALU_SLTU;
				endcase
				e.ex.alusel = (op == OP_ADDIU || op == OP_SLTI || op == OP_SLTIU)
					? SEL_ARITH : SEL_LOGIC;
				if (op == OP_LUI)
					imm = {ins[15:0], 16'h0};
				else if (e.ex.alusel == SEL_LOGIC)
					imm = {16'h0, ins[15:0]};
				else
					imm = {{16{ins[15]}}, ins[15:0]};
			end
			OP_J, OP_JAL: begin
				e.ex.aluop = (op == OP_JAL) ? ALU_JAL : ALU_J;
				e.ex.alusel = SEL_JB;
				e.ex.wd = 5'd31;
				e.ex.wreg = (op == OP_JAL);
				lnk = (op == OP_JAL);
				kind = K_ALW;
			end
			OP_BEQ, OP_BNE: begin
				e.ex.aluop = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				e.ex.alusel = SEL_JB;
				e.r1en = 1'b1;
				e.r2en = 1'b1;
				kind = (op == OP_BEQ) ? K_EQ : K_NE;
			end
			OP_BLEZ, OP_BGTZ: begin
				e.ex.aluop = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				e.ex.alusel = SEL_JB;
				e.r1en = 1'b1;
				kind = (op == OP_BGTZ) ? K_GTZ : K_LEZ;
				ill = (rt != 5'd0);
			end
			OP_REGIMM: begin
				e.ex.aluop = (rt == RT_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
				e.ex.alusel = SEL_JB;
				e.r1en = 1'b1;
				kind = (rt == RT_BGEZ) ? K_GEZ : K_LTZ;
				ill = (rt != RT_BGEZ && rt != RT_BLTZ);
			end
			OP_LW: begin
				e.ex.aluop = ALU_LW;
				e.ex.alusel = SEL_LS;
				e.r1en = 1'b1;
				e.ex.wreg = 1'b1;
				e.ex.wd = rt;
			end
			OP_SW: begin
				e.ex.aluop = ALU_SW;
				e.ex.alusel = SEL_LS;
				e.r1en = 1'b1;
				e.r2en = 1'b1;
			end
			default: ill = 1'b1;
		endcase
		if (ill) begin
			e.ex.aluop = ALU_NOP;
			e.ex.alusel = SEL_NOP;
			e.ex.wreg = 1'b0;
			e.r1en = 1'b0;
			e.r2en = 1'b0;
			imm = '0;
			lnk = 1'b0;
			kind = K_NONE;
		end
		e.ex.illegal = ill;
		e.ex.reg1 = pick_operand(e.r1en, rs, d1, imm);
		e.ex.reg2 = pick_operand(e.r2en, rt, d2, imm);
		e.stall = valid && ex_aluop == ALU_LW
			&& ((e.r1en && ex_wd == rs) || (e.r2en && ex_wd == rt));
		case (kind)
			K_ALW:   e.bflag = 1'b1;
			K_EQ:    e.bflag = (e.ex.reg1 == e.ex.reg2);
			K_NE:    e.bflag = (e.ex.reg1 != e.ex.reg2);
			K_GTZ:   e.bflag = ($signed(e.ex.reg1) > 0);
			K_LEZ:   e.bflag = ($signed(e.ex.reg1) <= 0);
			K_GEZ:   e.bflag = ($signed(e.ex.reg1) >= 0);
			K_LTZ:   e.bflag = ($signed(e.ex.reg1) < 0);
			default: e.bflag = 1'b0;
		endcase
		pc4 = pcv + 32'd4;
		if (kind == K_NONE)
			e.btarget = '0;
		else if (kind == K_ALW)
			e.btarget = (op == OP_SPECIAL) ? e.ex.reg1 : {pc4[31:28], ins[25:0], 2'b00};
		else
			e.btarget = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
		e.ex.link_addr = lnk ? pcv + 32'd8 : '0;
		return e;
	endfunction

	task automatic set_fwd(input alu_op_e aop, input logic ew, input logic [4:0] ewd,
		input logic [31:0] ewdata, input logic mw, input logic [4:0] mwd,
		input logic [31:0] mwdata);
		s_ex_aluop = aop;
		s_ex_wreg = ew;
		s_ex_wd = ewd;
		s_ex_wdata = ewdata;
		s_mem_wreg = mw;
		s_mem_wd = mwd;
		s_mem_wdata = mwdata;
	endtask

	// one decode cycle drives inputs, checks same-cycle outputs and queues the registered result
	task automatic step(input logic valid, input logic [31:0] ins, input logic [31:0] pcv,
		input logic [31:0] d1, input logic [31:0] d2);
		exp_t e;
		@(negedge clk);
		id_valid = valid;
		inst = ins;
		pc = pcv;
		rf1 = d1;
		rf2 = d2;
		ex_aluop = s_ex_aluop;
		ex_wreg = s_ex_wreg;
		ex_wd = s_ex_wd;
		ex_wdata = s_ex_wdata;
		mem_wreg = s_mem_wreg;
		mem_wd = s_mem_wd;
		mem_wdata = s_mem_wdata;
		#1;
		e = ref_decode(ins, pcv, d1, d2, valid);
		check_eq("reg1_read", 32'(e.r1en), 32'(reg1_read));
		check_eq("reg2_read", 32'(e.r2en), 32'(reg2_read));
		check_eq("reg1_addr", 32'(e.a1), 32'(reg1_addr));
		check_eq("reg2_addr", 32'(e.a2), 32'(reg2_addr));
		check_eq("stall", 32'(e.stall), 32'(stall));
		if (valid && !e.stall) begin
			check_eq("branch_flag", 32'(e.bflag), 32'(branch_flag));
			check_eq("branch_target", e.btarget, branch_target);
			e.ex.in_delayslot = ds_pending;
			ds_pending = e.bflag;
			exp_q.push_back(e.ex);
		end else begin
			exp_q.push_back('0);	// bubble
		end
	endtask

	// lw in execute writing lw_rd, then the load moves on to memory
	task automatic load_use_stall(input logic [31:0] ins, input logic [4:0] lw_rd,
		input logic [31:0] pcv);
		int   n;
		logic stalled;
		set_fwd(ALU_LW, 1'b1, lw_rd, 32'hdead_beef, 1'b0, 5'd0, 32'd0);
		step(1'b0, ins, pcv, 32'd1, 32'd2);	// no stall without a valid instruction
		step(1'b1, ins, pcv, 32'd1, 32'd2);
		check_eq("stall_raised", 32'd1, 32'(stall));
		// load now sits in memory
		set_fwd(ALU_NOP, 1'b0, 5'd0, 32'd0, 1'b1, lw_rd, 32'h0bad_f00d);
		n = 0;
		stalled = 1'b1;
		while (stalled) begin
			if (n == 8) begin
				$display("stall did not clear after the load moved on");
				$display("Regression failed");
				$fatal(1, "stall timeout");
			end
			step(1'b1, ins, pcv, 32'd1, 32'd2);
			stalled = stall;
			n++;
		end
		set_fwd(ALU_NOP, 1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
	endtask

	// comparing process
	initial begin
		id_ex_t x;
		forever begin
			@(posedge clk);
			#1;
			if (exp_q.size() > 0) begin
				x = exp_q.pop_front();
				check_eq("ex_valid", 32'(x.valid), 32'(ex_valid));
				check_eq("ex_aluop", 32'(x.aluop), 32'(ex_aluop_q));
				check_eq("ex_alusel", 32'(x.alusel), 32'(ex_alusel_q));
				check_eq("ex_wreg", 32'(x.wreg), 32'(ex_wreg_q));
				check_eq("ex_in_delayslot", 32'(x.in_delayslot), 32'(ex_in_ds));
				check_eq("ex_illegal", 32'(x.illegal), 32'(ex_illegal));
				if (x.valid) begin	// payload holds through bubbles
					check_eq("ex_reg1", x.reg1, ex_reg1);
					check_eq("ex_reg2", x.reg2, ex_reg2);
					check_eq("ex_wd", 32'(x.wd), 32'(ex_wd_q));
					check_eq("ex_link_addr", x.link_addr, ex_link);
				end
			end
		end
	end

	function automatic logic [5:0] reg_fn(input int k);
		case (k)
			0: return FN_OR;
			1: return FN_AND;
			2: return FN_XOR;
			3: return FN_NOR;
			4: return FN_ADDU;
			5: return FN_SUBU;
			6: return FN_SLT;
			7: return FN_SLTU;
			8: return FN_SLLV;
			9: return FN_SRLV;
			default: return FN_SRAV;
		endcase
	endfunction

	function automatic logic [5:0] imm_op(input int k);
		case (k)
			0: return OP_ORI;
			1: return OP_ANDI;
			2: return OP_XORI;
			3: return OP_LUI;
			4: return OP_ADDIU;
			5: return OP_SLTI;
			default: return OP_SLTIU;
		endcase
	endfunction

	function automatic logic [31:0] gen_alu();
		logic [31:0] r;
		int          k;
		r = rnd();
		k = int'(rnd() % 32'd22);
		if (k < 11)
			return {OP_SPECIAL, r[25:11], 5'd0, reg_fn(k)};
		if (k < 18)
			return {imm_op(k - 11), r[25:0]};
		if (k == 18)
			return {OP_SPECIAL, 5'd0, r[20:6], FN_SLL};
		if (k == 19)
			return {OP_SPECIAL, 5'd0, r[20:6], FN_SRL};
		if (k == 20)
			return {OP_SPECIAL, 5'd0, r[20:6], FN_SRA};
		return {r[31] ? OP_LW : OP_SW, r[25:0]};
	endfunction

	function automatic logic [31:0] gen_branch();
		logic [31:0] r;
		r = rnd();
		case (int'(rnd() % 32'd10))
			0: return {OP_BEQ, r[25:0]};
			1: return {OP_BNE, r[25:0]};
			2: return {OP_BLEZ, r[25:21], 5'd0, r[15:0]};
			3: return {OP_BGTZ, r[25:21], 5'd0, r[15:0]};
			4: return {OP_REGIMM, r[25:21], RT_BGEZ, r[15:0]};
			5: return {OP_REGIMM, r[25:21], RT_BLTZ, r[15:0]};
			6: return {OP_J, r[25:0]};
			7: return {OP_JAL, r[25:0]};
			8: return {OP_SPECIAL, r[25:21], 15'd0, FN_JR};
			default: return {OP_SPECIAL, r[25:21], 5'd0, r[15:11], 5'd0, FN_JALR};
		endcase
	endfunction

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] p;
		int          n;
		test_name = "reset";
		ds_pending = 1'b0;
		arst_n = 1'b0;
		id_valid = 1'b0;
		pc = '0;
		inst = '0;
		rf1 = '0;
		rf2 = '0;
		ex_aluop = ALU_NOP;
		ex_wreg = 1'b0;
		ex_wd = '0;
		ex_wdata = '0;
		mem_wreg = 1'b0;
		mem_wd = '0;
		mem_wdata = '0;
		set_fwd(ALU_NOP, 1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
		repeat (2) @(negedge clk);
		check_eq("ex_valid", 32'd0, 32'(ex_valid));
		check_eq("ex_wreg", 32'd0, 32'(ex_wreg_q));
		check_eq("ex_in_delayslot", 32'd0, 32'(ex_in_ds));
		arst_n = 1'b1;

		test_name = "idle";
		repeat (3) step(1'b0, rnd(), rnd(), rnd(), rnd());

		test_name = "alu_random";
		repeat (60) step(1'b1, gen_alu(), 32'h400, rnd(), rnd());

		test_name = "forwarding";
		set_fwd(ALU_ADDU, 1'b1, 5'd5, 32'h1111_1111, 1'b1, 5'd5, 32'h2222_2222);
		step(1'b1, {OP_SPECIAL, 5'd5, 5'd5, 5'd9, 5'd0, FN_ADDU}, 32'h500, rnd(), rnd());
		set_fwd(ALU_ADDU, 1'b1, 5'd6, 32'h1111_1111, 1'b1, 5'd5, 32'h2222_2222);
		step(1'b1, {OP_SPECIAL, 5'd5, 5'd5, 5'd9, 5'd0, FN_ADDU}, 32'h504, rnd(), rnd());
		set_fwd(ALU_ADDU, 1'b1, 5'd6, 32'h1111_1111, 1'b1, 5'd7, 32'h2222_2222);
		step(1'b1, {OP_SPECIAL, 5'd5, 5'd5, 5'd9, 5'd0, FN_ADDU}, 32'h508, rnd(), rnd());

		test_name = "load_use";
		load_use_stall({OP_SPECIAL, 5'd7, 5'd3, 5'd4, 5'd0, FN_SUBU}, 5'd7, 32'h600);
		load_use_stall({OP_SW, 5'd2, 5'd9, 16'h0010}, 5'd9, 32'h604);	// store data port

		test_name = "branch";
		repeat (40) begin
			a = rnd();
			b = rnd();
			if (a[0])
				b = a;	// equal operands for beq/bne
			if (b[1])
				a = '0;
			p = rnd();
			step(1'b1, gen_branch(), {p[31:2], 2'b00}, a, b);
			step(1'b1, gen_alu(), p + 32'd4, rnd(), rnd());
			step(1'b1, gen_alu(), p + 32'd8, rnd(), rnd());
		end

		test_name = "illegal";
		a = rnd();
		step(1'b1, {6'h3f, a[25:0]}, 32'h700, rnd(), rnd());
		step(1'b1, {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}, 32'h704, rnd(), rnd());
		step(1'b1, {OP_REGIMM, 5'd1, 5'd2, 16'h0010}, 32'h708, rnd(), rnd());
		step(1'b1, {OP_BGTZ, 5'd1, 5'd4, 16'h0010}, 32'h70c, rnd(), rnd());
		step(1'b1, {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd4, FN_ADDU}, 32'h710, rnd(), rnd());
		step(1'b0, 32'd0, 32'h714, 32'd0, 32'd0);

		n = 0;
		while (exp_q.size() > 0 && n < 10) begin
			@(posedge clk);
			n++;
		end
		#2;
		if (exp_q.size() != 0) begin
			$display("expected results were left unchecked");
			$display("Regression failed");
			$fatal(1, "drain timeout");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit import id_pkg::*; (
	input  logic [XLEN-1:0]   pc_i,
	input  logic [INST_W-1:0] inst_i,
	dec_if.sink               dec,
	input  logic [XLEN-1:0]   reg1_i,
	input  logic [XLEN-1:0]   reg2_i,
	output logic              branch_flag_o,
	output logic [XLEN-1:0]   branch_target_o,
	output logic [XLEN-1:0]   link_addr_o
);

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_plus8;
	logic [XLEN-1:0] br_offset;
	logic [XLEN-1:0] jmp_target;

	assign pc_plus4  = pc_i + 32'd4;
	assign pc_plus8  = pc_i + 32'd8;	// return past the delay slot
	assign br_offset = {{(XLEN-18){inst_i[15]}}, inst_i[15:0], 2'b00};

	// jr/jalr are the only jumps reading a register
	assign jmp_target = dec.reg1_read ? reg1_i
		: {pc_plus4[XLEN-1:XLEN-4], inst_i[25:0], 2'b00};

	always_comb begin
		case (dec.br_kind)
			BR_ALWAYS: branch_flag_o = 1'b1;
			BR_EQ:     branch_flag_o = (reg1_i == reg2_i);
			BR_NE:     branch_flag_o = (reg1_i != reg2_i);
			BR_GTZ:    branch_flag_o = !reg1_i[XLEN-1] && (reg1_i != '0);
			BR_LEZ:    branch_flag_o = reg1_i[XLEN-1] || (reg1_i == '0);
			BR_GEZ:    branch_flag_o = !reg1_i[XLEN-1];
			BR_LTZ:    branch_flag_o = reg1_i[XLEN-1];
			default:   branch_flag_o = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.br_kind)
			BR_NONE:   branch_target_o = '0;
			BR_ALWAYS: branch_target_o = jmp_target;
			default:   branch_target_o = pc_plus4 + br_offset;
		endcase
	end

	assign link_addr_o = dec.link_en ? pc_plus8 : '0;

endmodule

`default_nettype wire

// ==== hw/dec_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// decoded control of the instruction sitting in decode
interface dec_if import id_pkg::*; ();

	alu_op_e           aluop;
	alu_sel_e          alusel;
	br_kind_e          br_kind;
	logic              reg1_read;
	logic              reg2_read;
	logic [REG_AW-1:0] reg1_addr;
	logic [REG_AW-1:0] reg2_addr;
	logic [REG_AW-1:0] wd;
	logic              wreg;
	logic [XLEN-1:0]   imm;
	logic              link_en;	// jal / jalr
	logic              illegal;

	modport dec (
		output aluop, alusel, br_kind, reg1_read, reg2_read, reg1_addr, reg2_addr,
		output wd, wreg, imm, link_en, illegal
	);

	modport sink (
		input aluop, alusel, br_kind, reg1_read, reg2_read, reg1_addr, reg2_addr,
		input wd, wreg, imm, link_en, illegal
	);

endinterface

`default_nettype wire

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg import id_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            id_valid_i,
	dec_if.sink             dec,
	input  logic [XLEN-1:0] reg1_i,
	input  logic [XLEN-1:0] reg2_i,
	input  logic [XLEN-1:0] link_addr_i,
	input  logic            branch_flag_i,
	input  logic            hazard1_i,
	input  logic            hazard2_i,
	output logic            stall_o,
	output id_ex_t          ex_o
);

	logic              accept;
	logic              valid_q;
	alu_op_e           aluop_q;
	alu_sel_e          alusel_q;
	logic              wreg_q;
	logic              in_ds_q;
	logic              illegal_q;
	logic              ds_pending_q;	// previous accepted op was a taken branch
	logic [XLEN-1:0]   reg1_q;
	logic [XLEN-1:0]   reg2_q;
	logic [XLEN-1:0]   link_q;
	logic [REG_AW-1:0] wd_q;

	assign stall_o = id_valid_i && (hazard1_i || hazard2_i);
	assign accept  = id_valid_i && !stall_o;

	//////////////////////////////
	// control, bubble when nothing accepted
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q      <= 1'b0;
			aluop_q      <= ALU_NOP;
			alusel_q     <= SEL_NOP;
			wreg_q       <= 1'b0;
			in_ds_q      <= 1'b0;
			illegal_q    <= 1'b0;
			ds_pending_q <= 1'b0;
		end else if (accept) begin
			valid_q      <= 1'b1;
			aluop_q      <= dec.aluop;
			alusel_q     <= dec.alusel;
			wreg_q       <= dec.wreg;
			in_ds_q      <= ds_pending_q;
			illegal_q    <= dec.illegal;
			ds_pending_q <= branch_flag_i;	// set by a taken branch, cleared by its slot
		end else begin
			valid_q   <= 1'b0;
			aluop_q   <= ALU_NOP;
			alusel_q  <= SEL_NOP;
			wreg_q    <= 1'b0;
			in_ds_q   <= 1'b0;
			illegal_q <= 1'b0;
		end
	end

	// payload only moves on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			reg1_q <= reg1_i;
			reg2_q <= reg2_i;
			link_q <= link_addr_i;
			wd_q   <= dec.wd;
		end
	end

	assign ex_o = '{
		valid:        valid_q,
		aluop:        aluop_q,
		alusel:       alusel_q,
		reg1:         reg1_q,
		reg2:         reg2_q,
		wd:           wd_q,
		wreg:         wreg_q,
		link_addr:    link_q,
		in_delayslot: in_ds_q,
		illegal:      illegal_q
	};

endmodule

`default_nettype wire

// ==== hw/id_pkg.sv ====
`default_nettype none

package id_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;
	localparam int INST_W = 32;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// SPECIAL function codes, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM rt field
	localparam logic [4:0] RT_BLTZ = 5'b00000;
	localparam logic [4:0] RT_BGEZ = 5'b00001;

	localparam logic [REG_AW-1:0] LINK_REG = 5'd31;	// $ra

	//////////////////////////////
	// execute encodings
	//////////////////////////////
	typedef enum logic [4:0] {
		ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_ADDU, ALU_SUBU,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_LUI,	// executed as or of rs and the shifted immediate
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
		ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ, ALU_BGEZ, ALU_BLTZ,
		ALU_LW, ALU_SW
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JB, SEL_LS
	} alu_sel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
	} br_kind_e;

	// one writeback source seen by decode
	typedef struct packed {
		logic              wreg;
		logic [REG_AW-1:0] wd;
		logic [XLEN-1:0]   wdata;
	} fwd_t;

	typedef struct packed {
		logic              valid;
		alu_op_e           aluop;
		alu_sel_e          alusel;
		logic [XLEN-1:0]   reg1;
		logic [XLEN-1:0]   reg2;
		logic [REG_AW-1:0] wd;
		logic              wreg;
		logic [XLEN-1:0]   link_addr;
		logic              in_delayslot;
		logic              illegal;
	} id_ex_t;

endpackage

`default_nettype wire

// ==== hw/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage import id_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              id_valid_i,
	input  logic [XLEN-1:0]   pc_i,
	input  logic [INST_W-1:0] inst_i,
	input  logic [XLEN-1:0]   reg1_data_i,
	input  logic [XLEN-1:0]   reg2_data_i,
	input  alu_op_e           ex_aluop_i,
	input  logic              ex_wreg_i,
	input  logic [REG_AW-1:0] ex_wd_i,
	input  logic [XLEN-1:0]   ex_wdata_i,
	input  logic              mem_wreg_i,
	input  logic [REG_AW-1:0] mem_wd_i,
	input  logic [XLEN-1:0]   mem_wdata_i,
	output logic              reg1_read_o,
	output logic              reg2_read_o,
	output logic [REG_AW-1:0] reg1_addr_o,
	output logic [REG_AW-1:0] reg2_addr_o,
	output logic              stall_o,
	output logic              branch_flag_o,
	output logic [XLEN-1:0]   branch_target_o,
	output logic              ex_valid_o,
	output alu_op_e           ex_aluop_o,
	output alu_sel_e          ex_alusel_o,
	output logic [XLEN-1:0]   ex_reg1_o,
	output logic [XLEN-1:0]   ex_reg2_o,
	output logic [REG_AW-1:0] ex_wd_o,
	output logic              ex_wreg_o,
	output logic [XLEN-1:0]   ex_link_addr_o,
	output logic              ex_in_delayslot_o,
	output logic              ex_illegal_o
);

	fwd_t            ex_fwd;
	fwd_t            mem_fwd;
	logic [XLEN-1:0] reg1;
	logic [XLEN-1:0] reg2;
	logic [XLEN-1:0] link_addr;
	logic            hazard1;
	logic            hazard2;
	id_ex_t          ex_q;

	dec_if u_dec_if ();

	assign ex_fwd  = '{wreg: ex_wreg_i, wd: ex_wd_i, wdata: ex_wdata_i};
	assign mem_fwd = '{wreg: mem_wreg_i, wd: mem_wd_i, wdata: mem_wdata_i};

	inst_decoder u_dec (.inst_i(inst_i), .dec(u_dec_if));

	// one mux per register file read port
	operand_mux u_op1 (
		.dec(u_dec_if), .port_sel_i(1'b0), .reg_data_i(reg1_data_i),
		.ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .ex_aluop_i(ex_aluop_i),
		.operand_o(reg1), .load_hazard_o(hazard1)
	);
	operand_mux u_op2 (
		.dec(u_dec_if), .port_sel_i(1'b1), .reg_data_i(reg2_data_i),
		.ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .ex_aluop_i(ex_aluop_i),
		.operand_o(reg2), .load_hazard_o(hazard2)
	);

	branch_unit u_br (
		.pc_i(pc_i), .inst_i(inst_i), .dec(u_dec_if), .reg1_i(reg1), .reg2_i(reg2),
		.branch_flag_o(branch_flag_o), .branch_target_o(branch_target_o),
		.link_addr_o(link_addr)
	);

	id_ex_reg u_id_ex (
		.clk(clk), .arst_n_i(arst_n_i), .id_valid_i(id_valid_i), .dec(u_dec_if),
		.reg1_i(reg1), .reg2_i(reg2), .link_addr_i(link_addr),
		.branch_flag_i(branch_flag_o), .hazard1_i(hazard1), .hazard2_i(hazard2),
		.stall_o(stall_o), .ex_o(ex_q)
	);

	// register file read request
	assign reg1_read_o = u_dec_if.reg1_read;
	assign reg2_read_o = u_dec_if.reg2_read;
	assign reg1_addr_o = u_dec_if.reg1_addr;
	assign reg2_addr_o = u_dec_if.reg2_addr;

	assign ex_valid_o        = ex_q.valid;
	assign ex_aluop_o        = ex_q.aluop;
	assign ex_alusel_o       = ex_q.alusel;
	assign ex_reg1_o         = ex_q.reg1;
	assign ex_reg2_o         = ex_q.reg2;
	assign ex_wd_o           = ex_q.wd;
	assign ex_wreg_o         = ex_q.wreg;
	assign ex_link_addr_o    = ex_q.link_addr;
	assign ex_in_delayslot_o = ex_q.in_delayslot;
	assign ex_illegal_o      = ex_q.illegal;

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import id_pkg::*; (
	input  logic [INST_W-1:0] inst_i,
	dec_if.dec                dec
);

	logic [5:0]  opcode;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  shamt;
	logic [5:0]  funct;
	logic [15:0] imm16;
	logic        bad;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	always_comb begin
		// defaults, register form
		dec.aluop     = ALU_NOP;
		dec.alusel    = SEL_NOP;
		dec.br_kind   = BR_NONE;
		dec.reg1_read = 1'b0;
		dec.reg2_read = 1'b0;
		dec.reg1_addr = rs;
		dec.reg2_addr = rt;
		dec.wd        = rd;
		dec.wreg      = 1'b0;
		dec.imm       = '0;
		dec.link_en   = 1'b0;
		bad           = 1'b0;

		case (opcode)
			//////////////////////////////
			OP_SPECIAL: begin
				dec.reg1_read = 1'b1;
				dec.reg2_read = 1'b1;
				dec.wreg      = 1'b1;
				bad           = (shamt != 5'd0);
				case (funct)
					FN_OR:   dec.aluop = ALU_OR;
					FN_AND:  dec.aluop = ALU_AND;
					FN_XOR:  dec.aluop = ALU_XOR;
					FN_NOR:  dec.aluop = ALU_NOR;
					FN_ADDU: dec.aluop = ALU_ADDU;
					FN_SUBU: dec.aluop = ALU_SUBU;
					FN_SLT:  dec.aluop = ALU_SLT;
					FN_SLTU: dec.aluop = ALU_SLTU;
					FN_SLLV, FN_SLL: dec.aluop = ALU_SLL;
					FN_SRLV, FN_SRL: dec.aluop = ALU_SRL;
					FN_SRAV, FN_SRA: dec.aluop = ALU_SRA;
					FN_JR:   dec.aluop = ALU_JR;
					FN_JALR: dec.aluop = ALU_JALR;
					default: bad = 1'b1;
				endcase
				case (funct)
					FN_OR, FN_AND, FN_XOR, FN_NOR: dec.alusel = SEL_LOGIC;
					FN_SLLV, FN_SRLV, FN_SRAV, FN_SLL, FN_SRL, FN_SRA: dec.alusel = SEL_SHIFT;
					FN_JR, FN_JALR: dec.alusel = SEL_JB;
					default: dec.alusel = SEL_ARITH;
				endcase
				if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
					dec.reg1_read = 1'b0;	// shift amount comes in as operand 1
					dec.imm       = {{(XLEN-5){1'b0}}, shamt};
					bad           = (rs != 5'd0);
				end
				if (funct == FN_JR || funct == FN_JALR) begin
					dec.reg2_read = 1'b0;
					dec.br_kind   = BR_ALWAYS;
					dec.wreg      = (funct == FN_JALR);
					dec.link_en   = (funct == FN_JALR);
				end
			end
			//////////////////////////////
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				dec.reg1_read = 1'b1;
				dec.wreg      = 1'b1;
				dec.wd        = rt;
				dec.alusel    = SEL_ARITH;
				dec.imm       = {{(XLEN-16){imm16[15]}}, imm16};	// sign extended
				case (opcode)
					OP_ORI:   dec.aluop = ALU_OR;
					OP_ANDI:  dec.aluop = ALU_AND;
					OP_XORI:  dec.aluop = ALU_XOR;
					OP_LUI:   dec.aluop = ALU_LUI;
					OP_ADDIU: dec.aluop = ALU_ADDU;
					OP_SLTI:  dec.aluop = ALU_SLT;
					default:  dec.aluop = ALU_SLTU;
				endcase
				if (opcode == OP_ORI || opcode == OP_ANDI || opcode == OP_XORI) begin
					dec.alusel = SEL_LOGIC;
					dec.imm    = {{(XLEN-16){1'b0}}, imm16};
				end
				if (opcode == OP_LUI) begin
					dec.alusel = SEL_LOGIC;
					dec.imm    = {imm16, 16'h0000};
				end
			end
			//////////////////////////////
			OP_J, OP_JAL: begin
				dec.aluop   = (opcode == OP_JAL) ? ALU_JAL : ALU_J;
				dec.alusel  = SEL_JB;
				dec.br_kind = BR_ALWAYS;
				dec.wreg    = (opcode == OP_JAL);
				dec.link_en = (opcode == OP_JAL);
				dec.wd      = LINK_REG;
			end
			OP_BEQ, OP_BNE: begin
				dec.aluop     = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				dec.alusel    = SEL_JB;
				dec.br_kind   = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
				dec.reg1_read = 1'b1;
				dec.reg2_read = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				dec.aluop     = (opcode == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				dec.alusel    = SEL_JB;
				dec.br_kind   = (opcode == OP_BGTZ) ? BR_GTZ : BR_LEZ;
				dec.reg1_read = 1'b1;
				bad           = (rt != 5'd0);
			end
			OP_REGIMM: begin
				dec.aluop     = (rt == RT_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
				dec.alusel    = SEL_JB;
				dec.br_kind   = (rt == RT_BGEZ) ? BR_GEZ : BR_LTZ;
				dec.reg1_read = 1'b1;
				bad           = (rt != RT_BGEZ) && (rt != RT_BLTZ);	// no bgezal / bltzal
			end
			//////////////////////////////
			OP_LW: begin
				dec.aluop     = ALU_LW;
				dec.alusel    = SEL_LS;
				dec.reg1_read = 1'b1;	// base
				dec.wreg      = 1'b1;
				dec.wd        = rt;
			end
			OP_SW: begin
				dec.aluop     = ALU_SW;
				dec.alusel    = SEL_LS;
				dec.reg1_read = 1'b1;
				dec.reg2_read = 1'b1;	// store data
			end
			default: bad = 1'b1;
		endcase

		// unknown encodings become an inert nop
		if (bad) begin
			dec.aluop     = ALU_NOP;
			dec.alusel    = SEL_NOP;
			dec.br_kind   = BR_NONE;
			dec.reg1_read = 1'b0;
			dec.reg2_read = 1'b0;
			dec.wreg      = 1'b0;
			dec.imm       = '0;
			dec.link_en   = 1'b0;
		end
		dec.illegal = bad;
	end

endmodule

`default_nettype wire

// ==== hw/operand_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_mux import id_pkg::*; (
	dec_if.sink             dec,
	input  logic            port_sel_i,	// 0 = read port 1, 1 = read port 2
	input  logic [XLEN-1:0] reg_data_i,
	input  fwd_t            ex_fwd_i,
	input  fwd_t            mem_fwd_i,
	input  alu_op_e         ex_aluop_i,
	output logic [XLEN-1:0] operand_o,
	output logic            load_hazard_o
);

	logic              rd_en;
	logic [REG_AW-1:0] rd_addr;

	assign rd_en   = port_sel_i ? dec.reg2_read : dec.reg1_read;
	assign rd_addr = port_sel_i ? dec.reg2_addr : dec.reg1_addr;

	// youngest result wins, r0 not special
	always_comb begin
		if (!rd_en) begin
			operand_o = dec.imm;
		end else if (ex_fwd_i.wreg && (ex_fwd_i.wd == rd_addr)) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_fwd_i.wreg && (mem_fwd_i.wd == rd_addr)) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = reg_data_i;
		end
	end

	// lw result only exists after memory, so ex forwarding is not enough
	assign load_hazard_o = rd_en && (ex_aluop_i == ALU_LW) && (ex_fwd_i.wd == rd_addr);

endmodule

`default_nettype wire

// ==== id_stage.f ====
hw/id_pkg.sv
hw/dec_if.sv
hw/inst_decoder.sv
hw/operand_mux.sv
hw/branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
dv/tb_id_stage.sv
